// ==== common/cache_pkg.sv ====
////////////////////
// shared definitions for the cache and the burst RAM model
// address split widths, burst timing constants
// processor request/response, tag entry and burst command types
////////////////////

package cache_pkg;

  // address split |tag|line|col|byte|
  localparam int byte_bits  = 2;
  localparam int col_ix_w   = 3;
  localparam int col_count  = 8;
  localparam int line_ix_w  = 4;
  // backing RAM is 4 KiB, byte addressed
  localparam int ram_addr_w = 12;
  localparam int tag_w      = ram_addr_w - line_ix_w - col_ix_w - byte_bits;

  // burst RAM timing, in clock cycles
  localparam int cmd_gap      = 13;
  localparam int read_latency = 4;
  localparam int init_cycles  = 8;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  // processor request, only the low ram_addr_w address bits are decoded
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    be_t         be;
    word_t       wdata;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
  } cpu_rsp_t;

  // one entry per cache line in the tag RAM
  typedef struct packed {
    logic             dirty;
    logic             valid;
    logic [tag_w-1:0] tag;
  } tag_entry_t;

  // burst command, addr is a line aligned byte address
  typedef struct packed {
    logic                  write;
    logic [ram_addr_w-1:0] addr;
    logic [7:0]            len;
  } burst_cmd_t;

endpackage

// ==== src/bram.sv ====
////////////////////
// single port block RAM
// per-byte write enables, synchronous read
////////////////////

`timescale 1ns/10ps

module bram #(
  parameter type word_type = cache_pkg::word_t
) (
  input  logic                            clk,
  input  cache_pkg::be_t                  we,
  input  logic [cache_pkg::line_ix_w-1:0] addr,
  input  word_type                        wdata,
  output word_type                        rdata
);

  import cache_pkg::*;

  localparam int depth = 2 ** line_ix_w;
  localparam int width = $bits(word_type);

  logic [width-1:0] mem [depth];
  logic [width-1:0] wbits;
  logic [width-1:0] rbits;

  // flat view of the stored word, byte lanes are 8 bits each
  assign wbits = wdata;
  assign rdata = rbits;

  always_ff @(posedge clk) begin
    // each bit follows the enable of its byte lane
    for (int i = 0; i < width; i++) begin
      if (we[i / 8]) begin
        mem[addr][i] <= wbits[i];
      end
    end
    // read returns the old contents on a write to the same entry
    rbits <= mem[addr];
  end

endmodule

// ==== cache/cache.sv ====
////////////////////
// direct-mapped write-back cache controller
// hit path, tag check, dirty line write-back burst,
// line fill burst and command spacing
////////////////////

`timescale 1ns/10ps

module cache (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  cache_pkg::cpu_req_t   req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output cache_pkg::cpu_rsp_t   rsp,
  input  logic                  init_done,
  output logic                  cmd_en,
  output cache_pkg::burst_cmd_t cmd,
  // only watched by the checker
  input  logic                  cmd_ack,
  output cache_pkg::word_t      wr_data,
  input  cache_pkg::word_t      rd_data
);

  import cache_pkg::*;

  typedef enum logic [2:0] {
    st_clear,
    st_idle,
    st_wb,
    st_fill_wait,
    st_fill,
    st_tag,
    st_done
  } state_t;

  localparam int gap_w  = $clog2(cmd_gap + 1);
  localparam int lat_w  = $clog2(read_latency + 1);
  localparam int low_w  = col_ix_w + byte_bits;

  state_t state;

  logic [col_ix_w-1:0]   col_ix;
  logic [line_ix_w-1:0]  line_ix;
  logic [tag_w-1:0]      req_tag;
  logic [line_ix_w-1:0]  clr_ix;
  logic [line_ix_w-1:0]  ram_addr;
  logic [col_ix_w-1:0]   beat;
  logic [col_ix_w-1:0]   wb_col;
  logic [lat_w-1:0]      lat_cnt;
  logic                  rd_pending;
  logic [gap_w-1:0]      gap_cnt;
  logic                  gap_ok;
  logic [ram_addr_w-1:0] victim_addr;
  logic [ram_addr_w-1:0] fill_addr;

  tag_entry_t tag_rdata;
  tag_entry_t tag_wdata;
  logic       tag_wr;
  be_t        col_we    [col_count];
  word_t      col_wdata [col_count];
  word_t      col_rdata [col_count];

  logic                 any_we;
  logic                 look_ok_q;
  logic [line_ix_w-1:0] look_line_q;
  logic                 fresh;
  logic                 hit;
  logic                 accept;
  logic                 miss;
  logic                 victim_dirty;
  logic                 issue_wb;
  logic                 issue_rd;

  // address fields
  assign col_ix  = req.addr[byte_bits +: col_ix_w];
  assign line_ix = req.addr[low_w +: line_ix_w];
  assign req_tag = req.addr[low_w + line_ix_w +: tag_w];

  // tag sweep owns the RAM address right after reset
  assign ram_addr = (state == st_clear) ? clr_ix : line_ix;

  // line base addresses in the burst RAM
  assign victim_addr = {tag_rdata.tag, line_ix, {low_w{1'b0}}};
  assign fill_addr   = {req_tag, line_ix, {low_w{1'b0}}};

  bram #(
    .word_type(tag_entry_t)
  ) u_tag (
    .clk   (clk),
    .we    ({4{tag_wr}}),
    .addr  (ram_addr),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

  // one RAM per word column, the whole line is read in parallel
  for (genvar i = 0; i < col_count; i++) begin : g_col
    bram #(
      .word_type(word_t)
    ) u_col (
      .clk   (clk),
      .we    (col_we[i]),
      .addr  (ram_addr),
      .wdata (col_wdata[i]),
      .rdata (col_rdata[i])
    );
  end

  // RAM outputs are only trusted when last cycle read this line
  // and nothing was written that cycle
  assign fresh = look_ok_q && (look_line_q == line_ix);

  assign hit = (state == st_idle) && fresh && tag_rdata.valid && (tag_rdata.tag == req_tag);

  assign req_ready = init_done && hit;
  assign accept    = req_valid && req_ready;
  assign rsp_valid = accept && !req.write;
  assign rsp.rdata = col_rdata[col_ix];

  assign miss         = (state == st_idle) && init_done && req_valid && fresh && !hit;
  assign victim_dirty = tag_rdata.valid && tag_rdata.dirty;

  // a command leaves only once the spacing rule allows it
  assign issue_wb = miss && gap_ok && victim_dirty;
  assign issue_rd = (miss && gap_ok && !victim_dirty) ||
                    ((state == st_fill_wait) && rd_pending && gap_ok);

  // RAM write side
  always_comb begin
    tag_wr    = 1'b0;
    tag_wdata = '0;
    for (int i = 0; i < col_count; i++) begin
      col_we[i]    = '0;
      col_wdata[i] = rd_data;
    end
    case (state)
      // zero entry marks the line invalid
      st_clear: tag_wr = 1'b1;
      st_idle: begin
        if (accept && req.write) begin
          // write hit: merge bytes and mark the line dirty
          tag_wr             = 1'b1;
          tag_wdata          = '{dirty: 1'b1, valid: 1'b1, tag: req_tag};
          col_we[col_ix]     = req.be;
          col_wdata[col_ix]  = req.wdata;
        end
      end
      // fill word goes straight from the bus into its column
      st_fill: col_we[beat] = '1;
      st_tag: begin
        tag_wr    = 1'b1;
        tag_wdata = '{dirty: 1'b0, valid: 1'b1, tag: req_tag};
      end
      default: ;
    endcase
  end

  always_comb begin
    any_we = tag_wr;
    for (int i = 0; i < col_count; i++) begin
      any_we = any_we | (|col_we[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      look_ok_q   <= 1'b0;
      look_line_q <= '0;
    end else begin
      look_ok_q   <= !any_we;
      look_line_q <= ram_addr;
    end
  end

  // cycles since the last command pulse, saturating
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gap_cnt <= gap_w'(cmd_gap);
    end else if (cmd_en) begin
      gap_cnt <= gap_w'(1);
    end else if (gap_cnt != gap_w'(cmd_gap)) begin
      gap_cnt <= gap_cnt + 1'b1;
    end
  end

  // decision is one cycle before the registered pulse
  assign gap_ok = !cmd_en && (gap_cnt >= gap_w'(cmd_gap - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_clear;
      clr_ix     <= '0;
      beat       <= '0;
      lat_cnt    <= '0;
      rd_pending <= 1'b0;
      cmd_en     <= 1'b0;
    end else begin
      cmd_en <= issue_wb || issue_rd;
      case (state)
        st_clear: begin
          clr_ix <= clr_ix + 1'b1;
          if (clr_ix == '1) begin
            state <= st_idle;
          end
        end
        st_idle: begin
          if (issue_wb) begin
            // word 0 leaves with the command, the loop sends 1..7
            beat       <= col_ix_w'(1);
            rd_pending <= 1'b1;
            state      <= st_wb;
          end else if (issue_rd) begin
            lat_cnt    <= lat_w'(read_latency - 1);
            rd_pending <= 1'b0;
            state      <= st_fill_wait;
          end
        end
        st_wb: begin
          beat <= beat + 1'b1;
          if (beat == '1) begin
            state <= st_fill_wait;
          end
        end
        st_fill_wait: begin
          if (rd_pending) begin
            // fill command still held back by the spacing rule
            if (gap_ok) begin
              rd_pending <= 1'b0;
              lat_cnt    <= lat_w'(read_latency - 1);
            end
          end else if (lat_cnt == '0) begin
            beat  <= '0;
            state <= st_fill;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        st_fill: begin
          beat <= beat + 1'b1;
          if (beat == '1) begin
            state <= st_tag;
          end
        end
        st_tag: state <= st_done;
        // let the RAM outputs settle on the new line
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // victim word for the bus, column 0 at the command cycle
  assign wb_col = (state == st_wb) ? beat : '0;

  always_ff @(posedge clk) begin
    if (issue_wb) begin
      cmd <= '{write: 1'b1, addr: victim_addr, len: 8'(col_count)};
    end else if (issue_rd) begin
      cmd <= '{write: 1'b0, addr: fill_addr, len: 8'(col_count)};
    end
    wr_data <= col_rdata[wb_col];
  end

endmodule

// ==== burst_ram/burst_ram.sv ====
////////////////////
// burst RAM controller model
// init delay, command acknowledge, burst write capture,
// fixed latency read pipeline, 4 KiB word storage
////////////////////

`timescale 1ns/10ps

module burst_ram (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  init_done,
  input  logic                  cmd_en,
  input  cache_pkg::burst_cmd_t cmd,
  output logic                  cmd_ack,
  input  cache_pkg::word_t      wr_data,
  output cache_pkg::word_t      rd_data
);

  import cache_pkg::*;

  localparam int word_ix_w = ram_addr_w - byte_bits;
  localparam int words     = 2 ** word_ix_w;
  localparam int init_w    = $clog2(init_cycles + 1);

  word_t                mem [words];
  logic [init_w-1:0]    init_cnt;
  logic [word_ix_w-1:0] cmd_ix;
  logic [word_ix_w-1:0] burst_ix;
  logic [word_ix_w-1:0] cur_ix;
  logic [7:0]           burst_left;
  logic                 burst_write;
  logic                 wr_go;
  logic                 rd_go;
  word_t                rd_word;
  word_t                rd_pipe [read_latency];

  assign cmd_ix = cmd.addr[ram_addr_w-1:byte_bits];

  // word 0 is handled in the command cycle itself,
  // the counter covers the remaining words
  assign cur_ix = cmd_en ? cmd_ix : burst_ix;
  assign wr_go  = cmd_en ? cmd.write : ((burst_left != '0) && burst_write);
  assign rd_go  = cmd_en ? !cmd.write : ((burst_left != '0) && !burst_write);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_cnt    <= '0;
      init_done   <= 1'b0;
      cmd_ack     <= 1'b0;
      burst_left  <= '0;
      burst_write <= 1'b0;
      burst_ix    <= '0;
    end else begin
      cmd_ack <= cmd_en;
      // power-up countdown
      if (!init_done) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == init_w'(init_cycles - 1)) begin
          init_done <= 1'b1;
        end
      end
      // a new command restarts the burst counter
      if (cmd_en) begin
        burst_write <= cmd.write;
        burst_ix    <= cmd_ix + 1'b1;
        burst_left  <= (cmd.len == '0) ? '0 : cmd.len - 8'd1;
      end else if (burst_left != '0) begin
        burst_ix   <= burst_ix + 1'b1;
        burst_left <= burst_left - 8'd1;
      end
    end
  end

  // storage, each word starts as 0xC0DE over its byte address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < words; i++) begin
        mem[i] <= {16'hC0DE, 16'(i << byte_bits)};
      end
    end else if (wr_go) begin
      mem[cur_ix] <= wr_data;
    end
  end

  // idle cycles push zeros through the pipe
  assign rd_word = rd_go ? mem[cur_ix] : '0;

  // word k shows up read_latency + k cycles after the command
  always_ff @(posedge clk) begin
    rd_pipe[0] <= rd_word;
    for (int i = 1; i < read_latency; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[read_latency-1];

endmodule

// ==== src/cache_top.sv ====
////////////////////
// top level
// cache controller in front of the burst RAM model
////////////////////

`timescale 1ns/10ps

module cache_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  cache_pkg::cpu_req_t req,
  output logic                req_ready,
  output logic                rsp_valid,
  output cache_pkg::cpu_rsp_t rsp
);

  import cache_pkg::*;

  // memory side of the cache
  logic       init_done;
  logic       cmd_en;
  logic       cmd_ack;
  burst_cmd_t cmd;
  word_t      wr_data;
  word_t      rd_data;

  cache u_cache (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .init_done (init_done),
    .cmd_en    (cmd_en),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .wr_data   (wr_data),
    .rd_data   (rd_data)
  );

  // stands in for the vendor controller IP
  burst_ram u_burst_ram (
    .clk       (clk),
    .rst_n     (rst_n),
    .init_done (init_done),
    .cmd_en    (cmd_en),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .wr_data   (wr_data),
    .rd_data   (rd_data)
  );

endmodule

// ==== tests/tb_clock.sv ====
////////////////////
// testbench clock and reset
// 100 ns clock, reset held for 4 cycles
////////////////////

`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 50;
  localparam int reset_cycles = 4;
  // release lands just after an edge, like the stimulus
  localparam int release_delay = 10;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #release_delay;
    rst_n = 1'b1;
  end

endmodule

// ==== tests/cache_checker.sv ====
////////////////////
// concurrent assertions bound into the cache
// processor handshake rules, memory command spacing
////////////////////

`timescale 1ns/10ps

module cache_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                req_valid,
  input cache_pkg::cpu_req_t req,
  input logic                req_ready,
  input logic                rsp_valid,
  input cache_pkg::cpu_rsp_t rsp,
  input logic                cmd_en,
  input logic                cmd_ack
);

  import cache_pkg::*;

  localparam int gap_w = $clog2(cmd_gap + 1);

  // cycles since the previous command pulse, saturating
  logic [gap_w-1:0] since_cmd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      since_cmd <= gap_w'(cmd_gap);
    end else if (cmd_en) begin
      since_cmd <= gap_w'(1);
    end else if (since_cmd != gap_w'(cmd_gap)) begin
      since_cmd <= since_cmd + 1'b1;
    end
  end

  // command pulses at least cmd_gap cycles apart
  a_cmd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_en |-> since_cmd >= gap_w'(cmd_gap))
    else $error("cmd_en came sooner than cmd_gap cycles after the last one");

  // the RAM answers each pulse on the next cycle
  a_cmd_ack: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_en |=> cmd_ack)
    else $error("cmd_ack missing one cycle after cmd_en");

  // a stalled request keeps valid and payload
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request changed or dropped while stalled");

  // a read response only ever comes from a filled line
  a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !$isunknown(rsp))
    else $error("read response carries unknown data");

endmodule

bind cache cache_checker u_cache_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .req       (req),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .rsp       (rsp),
  .cmd_en    (cmd_en),
  .cmd_ack   (cmd_ack)
);

// ==== tests/cache_tb.sv ====
////////////////////
// cache testbench top
// vector reader, request driver, LFSR idle gaps,
// compare tasks and the closing summary
////////////////////

`timescale 1ns/10ps

module cache_tb;

  import cache_pkg::*;

  localparam int fields        = 6;
  localparam int max_vectors   = 64;
  localparam int drive_delay   = 10;
  localparam int ready_timeout = 200;
  localparam int reset_timeout = 20;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  cpu_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  cpu_rsp_t rsp;

  // six hex fields per vector, unused slots stay all ones
  logic [31:0] vec [fields * max_vectors];
  logic [7:0]  lfsr_state;
  logic        timed_out;
  int          errors;
  int          checks;
  int          test_errors;
  int          test_checks;
  int          tests_run;

  tb_clock u_tb_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cache_top u_cache_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  // galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    logic [7:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 8'hB8;
    end
    return n;
  endfunction

  // two LFSR bits give 0 to 3 idle cycles
  task automatic idle_gap();
    int n;
    n = 0;
    for (int b = 0; b < 2; b++) begin
      n = n | (int'(lfsr_state[0]) << b);
      lfsr_state = lfsr_next(lfsr_state);
    end
    repeat (n) begin
      @(posedge clk);
      #drive_delay;
    end
  endtask

  task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp, input string name);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got.rdata, exp.rdata);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic string test_title(input int num);
    case (num)
      1: return "reset state";
      2: return "read fill";
      3: return "byte enabled write merge";
      4: return "dirty eviction";
      5: return "clean replacement";
      default: return "vectors";
    endcase
  endfunction

  task automatic report_test(input int num);
    $display("test %0d %s: %0d checks, %0d errors", num, test_title(num),
             test_checks, test_errors);
    tests_run++;
    test_checks = 0;
    test_errors = 0;
  endtask

  // outputs stay low through reset and the RAM init delay
  task automatic check_reset();
    int cnt;
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < reset_timeout) begin
      @(negedge clk);
      check_flag(req_ready, 1'b0, "req_ready");
      check_flag(rsp_valid, 1'b0, "rsp_valid");
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      timed_out = 1'b1;
      errors++;
      $display("timeout: reset was never released");
    end else begin
      for (int i = 0; i < init_cycles; i++) begin
        @(negedge clk);
        check_flag(req_ready, 1'b0, "req_ready");
        check_flag(rsp_valid, 1'b0, "rsp_valid");
      end
    end
  endtask

  // called a drive_delay after a rising edge
  // outputs are sampled at the falling edge, the transfer is the next rising edge
  task automatic send_req(input logic write, input logic [31:0] addr, input be_t be,
                          input word_t wdata, output logic accepted,
                          output logic got_valid, output cpu_rsp_t got);
    int cnt;
    cnt       = 0;
    accepted  = 1'b0;
    got_valid = 1'b0;
    got       = '0;
    req       = '{addr: addr, write: write, be: be, wdata: wdata};
    req_valid = 1'b1;
    while (!accepted && cnt < ready_timeout) begin
      @(negedge clk);
      if (req_ready) begin
        accepted  = 1'b1;
        got_valid = rsp_valid;
        got       = rsp;
      end else begin
        cnt++;
      end
    end
    @(posedge clk);
    #drive_delay;
    req_valid = 1'b0;
  endtask

  initial begin
    int       idx;
    int       cur_test;
    int       num;
    logic     write;
    logic     accepted;
    logic     got_valid;
    be_t      be;
    word_t    wdata;
    cpu_rsp_t exp;
    cpu_rsp_t got;
    logic [31:0] addr;

    req_valid   = 1'b0;
    req         = '0;
    lfsr_state  = 8'd10;
    timed_out   = 1'b0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    test_checks = 0;
    tests_run   = 0;
    for (int i = 0; i < fields * max_vectors; i++) begin
      vec[i] = '1;
    end
    $readmemh("tests/cache_vectors.txt", vec);

    check_reset();
    report_test(1);

    if (vec[0] == '1) begin
      errors++;
      $display("no vectors could be read from tests/cache_vectors.txt");
    end

    @(posedge clk);
    #drive_delay;
    idx      = 0;
    cur_test = int'(vec[0]);
    while (!timed_out && idx < max_vectors && vec[idx * fields] != '1) begin
      num = int'(vec[idx * fields]);
      if (num != cur_test) begin
        report_test(cur_test);
        cur_test = num;
      end
      write     = vec[idx * fields + 1][0];
      addr      = vec[idx * fields + 2];
      be        = vec[idx * fields + 3][3:0];
      wdata     = vec[idx * fields + 4];
      exp.rdata = vec[idx * fields + 5];
      send_req(write, addr, be, wdata, accepted, got_valid, got);
      if (!accepted) begin
        timed_out = 1'b1;
        errors++;
        test_errors++;
        $display("timeout: req_ready stayed low in test %0d, vector %0d", cur_test, idx);
      end else begin
        // reads answer in the transfer cycle, writes never do
        check_flag(got_valid, !write, "rsp_valid");
        if (!write) begin
          check_rsp(got, exp, "rsp.rdata");
        end
      end
      idle_gap();
      idx++;
    end
    if (idx > 0) begin
      report_test(cur_test);
    end

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/cache_vectors.txt ====
// columns: test op addr be wdata expected, all hex
// op 0 is a read, op 1 a write; expected is ignored for writes
// test 2: first read misses, same line reads hit
2 0 000 f 00000000 c0de0000
2 0 004 f 00000000 c0de0004
2 0 01c f 00000000 c0de001c
2 0 010 f 00000000 c0de0010
// test 3: partial byte enables merge with the old word
3 0 024 f 00000000 c0de0024
3 1 024 3 aabbccdd 00000000
3 0 024 f 00000000 c0deccdd
3 1 028 c 12345678 00000000
3 0 028 f 00000000 12340028
3 1 03c 2 0000ab00 00000000
3 0 03c f 00000000 c0deab3c
// test 4: dirty lines written back and refilled
4 1 040 f deadbeef 00000000
4 1 05c 1 00000077 00000000
4 0 240 f 00000000 c0de0240
4 0 040 f 00000000 deadbeef
4 0 05c f 00000000 c0de0077
4 0 044 f 00000000 c0de0044
4 0 224 f 00000000 c0de0224
4 0 024 f 00000000 c0deccdd
4 0 03c f 00000000 c0deab3c
4 1 640 f 01020304 00000000
4 0 040 f 00000000 deadbeef
4 0 640 f 00000000 01020304
// test 5: conflicting clean lines on line 5
5 0 0a8 f 00000000 c0de00a8
5 0 2a8 f 00000000 c0de02a8
5 0 0b0 f 00000000 c0de00b0
5 0 2b4 f 00000000 c0de02b4
5 0 ea0 f 00000000 c0de0ea0
5 0 0a0 f 00000000 c0de00a0
5 0 ebc f 00000000 c0de0ebc

// ==== verilog.f ====
common/cache_pkg.sv
src/bram.sv
cache/cache.sv
burst_ram/burst_ram.sv
src/cache_top.sv
tests/tb_clock.sv
tests/cache_checker.sv
tests/cache_tb.sv

// ==== Makefile ====
TOP = cache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
